//--- Bender.yml
package:
  name: token_engine

sources:
  - files:
      - src/token_pkg.sv
      - src/pass_sequencer.sv
      - src/glb_req_gen.sv
      - src/glb_port.sv
      - src/weight_unpacker.sv
      - src/token_engine.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_token_engine.sv

//--- build.f
+incdir+tests
src/token_pkg.sv
src/pass_sequencer.sv
src/glb_req_gen.sv
src/glb_port.sv
src/weight_unpacker.sv
src/token_engine.sv
tests/tb_token_engine.sv

//--- src/glb_port.sv
`timescale 1ns/100ps

module glb_port import token_pkg::*; #(
    parameter int NUM_FIFO = 8
) (
    input  logic                clk,
    input  logic                rst_i,

    input  glb_req_t            req_i,
    input  logic [DATA_W-1:0]   glb_read_data_i,
    input  logic [DATA_W-1:0]   opsum_fifo_pop_data_matrix_i [NUM_FIFO-1:0],

    // GLB side
    output logic [ADDR_W-1:0]   glb_addr_o,
    output logic [3:0]          glb_web_o,
    output logic [DATA_W-1:0]   glb_write_data_o,

    // ifmap FIFO side
    output logic [NUM_FIFO-1:0] ifmap_fifo_push_matrix_o,
    output logic [DATA_W-1:0]   ifmap_fifo_push_data_o,

    // to the weight unpacker
    output logic                weight_word_valid_o,
    output logic [DATA_W-1:0]   weight_word_o
);

    localparam int IDX_W = (NUM_FIFO > 1) ? $clog2(NUM_FIFO) : 1;

    glb_req_t         req_q;       // what is on the port this cycle

    // tag of the read issued last cycle
    logic             rd_valid_q;
    req_kind_e        rd_kind_q;
    logic [IDX_W-1:0] rd_idx_q;

    logic             port_write;
    logic [IDX_W-1:0] wr_idx;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_q <= '0;
        end else begin
            req_q <= req_i;
        end
    end

    assign port_write = req_q.valid && req_q.write;
    assign wr_idx     = req_q.fifo_idx[IDX_W-1:0];

    assign glb_addr_o       = req_q.addr;
    assign glb_web_o        = port_write ? 4'b1111 : 4'b0000;
    assign glb_write_data_o = opsum_fifo_pop_data_matrix_i[wr_idx];  // popped last cycle

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= req_q.valid && !req_q.write;
        end
    end

    always_ff @(posedge clk) begin
        rd_kind_q <= req_q.kind;
        rd_idx_q  <= req_q.fifo_idx[IDX_W-1:0];
    end

    // read data returns one cycle after the address, steer it by tag
    always_comb begin
        ifmap_fifo_push_matrix_o = '0;
        if (rd_valid_q && (rd_kind_q == IFMAP)) begin
            ifmap_fifo_push_matrix_o = NUM_FIFO'(1) << rd_idx_q;
        end
    end

    assign ifmap_fifo_push_data_o = glb_read_data_i;

    assign weight_word_valid_o = rd_valid_q && (rd_kind_q == WEIGHT);
    assign weight_word_o       = glb_read_data_i;

endmodule

//--- src/glb_req_gen.sv
`timescale 1ns/100ps

module glb_req_gen import token_pkg::*; #(
    parameter int NUM_FIFO = 8,
    parameter int NUM_PE   = 8
) (
    input  logic                clk,
    input  logic                rst_i,

    input  phase_e              phase_i,
    input  pass_cfg_t           cfg_i,

    input  logic [NUM_FIFO-1:0] ifmap_fifo_full_matrix_i,
    input  logic [NUM_FIFO-1:0] opsum_fifo_empty_matrix_i,

    output glb_req_t            req_o,
    output logic [NUM_FIFO-1:0] opsum_fifo_pop_matrix_o,
    output logic                fill_done_o,
    output logic                drain_done_o
);

    localparam int IDX_W        = (NUM_FIFO > 1) ? $clog2(NUM_FIFO) : 1;
    localparam int PACE_W       = $clog2(BYTES_PER_WORD);
    localparam int WEIGHT_WORDS = NUM_PE / BYTES_PER_WORD;
    localparam int BYTE_SHIFT   = $clog2(BYTES_PER_WORD);

    logic [IDX_W-1:0]  idx_q;
    logic [7:0]        word_cnt_q;
    logic [PACE_W-1:0] pace_q;    // one weight read per unpacked word

    logic              weight_fire;
    logic              stream_fire;
    logic              last_word;
    logic              last_idx;
    logic [7:0]        word_limit;
    logic [ADDR_W-1:0] stream_base;
    logic [ADDR_W-1:0] stream_word_addr;
    logic [ADDR_W-1:0] weight_word_addr;

    assign weight_fire = (phase_i == WEIGHT_LOAD) && (pace_q == '0)
                         && (word_cnt_q < 8'(WEIGHT_WORDS));

    // stall while the current FIFO cannot take or give a word
    assign stream_fire = ((phase_i == IFMAP_FILL) && !ifmap_fifo_full_matrix_i[idx_q])
                         || ((phase_i == OPSUM_DRAIN) && !opsum_fifo_empty_matrix_i[idx_q]);

    assign word_limit  = (phase_i == OPSUM_DRAIN) ? cfg_i.out_c : cfg_i.in_c;
    assign stream_base = (phase_i == OPSUM_DRAIN) ? cfg_i.opsum_base : cfg_i.ifmap_base;
    assign last_word   = (word_cnt_q == word_limit - 8'd1);
    assign last_idx    = (idx_q == IDX_W'(NUM_FIFO - 1));

    // FIFO-major layout: base + idx * words + word
    assign stream_word_addr = stream_base + ADDR_W'(idx_q) * ADDR_W'(word_limit)
                              + ADDR_W'(word_cnt_q);
    assign weight_word_addr = cfg_i.weight_base + ADDR_W'(word_cnt_q);

    assign fill_done_o  = (phase_i == IFMAP_FILL) && stream_fire && last_word && last_idx;
    assign drain_done_o = (phase_i == OPSUM_DRAIN) && stream_fire && last_word && last_idx;

    always_comb begin
        req_o                   = '0;
        opsum_fifo_pop_matrix_o = '0;
        case (phase_i)
            WEIGHT_LOAD: begin
                req_o.valid = weight_fire;
                req_o.addr  = weight_word_addr << BYTE_SHIFT;
                req_o.kind  = WEIGHT;
            end
            IFMAP_FILL: begin
                req_o.valid    = stream_fire;
                req_o.addr     = stream_word_addr << BYTE_SHIFT;
                req_o.fifo_idx = 8'(idx_q);
                req_o.kind     = IFMAP;
            end
            OPSUM_DRAIN: begin
                req_o.valid    = stream_fire;
                req_o.write    = 1'b1;
                req_o.addr     = stream_word_addr << BYTE_SHIFT;
                req_o.fifo_idx = 8'(idx_q);
                req_o.kind     = OPSUM;
                opsum_fifo_pop_matrix_o[idx_q] = stream_fire;  // data comes next cycle
            end
            default: begin
                req_o.kind = WEIGHT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            idx_q      <= '0;
            word_cnt_q <= '0;
            pace_q     <= '0;
        end else begin
            case (phase_i)
                WEIGHT_LOAD: begin
                    pace_q <= (pace_q == PACE_W'(BYTES_PER_WORD - 1)) ? '0 : pace_q + 1'b1;
                    if (weight_fire) begin
                        word_cnt_q <= word_cnt_q + 8'd1;
                    end
                end
                IFMAP_FILL, OPSUM_DRAIN: begin
                    if (stream_fire) begin
                        if (last_word) begin
                            word_cnt_q <= '0;
                            idx_q      <= last_idx ? '0 : idx_q + 1'b1;  // wraps on done
                        end else begin
                            word_cnt_q <= word_cnt_q + 8'd1;
                        end
                    end
                end
                default: begin
                    // idle, reset and done phases clear the walk
                    idx_q      <= '0;
                    word_cnt_q <= '0;
                    pace_q     <= '0;
                end
            endcase
        end
    end

endmodule

//--- src/pass_sequencer.sv
`timescale 1ns/100ps

module pass_sequencer import token_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,

    input  logic   pass_start_i,
    input  logic   weight_done_i,   // last weight byte out
    input  logic   fill_done_i,     // last ifmap read accepted
    input  logic   drain_done_i,    // last opsum pop accepted

    output phase_e phase_o,
    output logic   ifmap_fifo_reset_o,
    output logic   opsum_fifo_reset_o,
    output logic   pass_done_o
);

    phase_e phase_q;
    phase_e phase_d;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            IDLE: begin
                if (pass_start_i) begin
                    phase_d = WEIGHT_LOAD;
                end
            end
            WEIGHT_LOAD: begin
                if (weight_done_i) begin
                    phase_d = FIFO_RESET;
                end
            end
            FIFO_RESET: begin
                phase_d = IFMAP_FILL;  // single cycle
            end
            IFMAP_FILL: begin
                if (fill_done_i) begin
                    phase_d = OPSUM_DRAIN;
                end
            end
            OPSUM_DRAIN: begin
                if (drain_done_i) begin
                    phase_d = DONE;
                end
            end
            DONE: begin
                phase_d = IDLE;
            end
            default: begin
                phase_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            phase_q <= IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign phase_o = phase_q;

    // both FIFO groups are flushed in the same cycle
    assign ifmap_fifo_reset_o = (phase_q == FIFO_RESET);
    assign opsum_fifo_reset_o = (phase_q == FIFO_RESET);

    // DONE is entered one cycle after the last pop, when its write is on the port
    assign pass_done_o = (phase_q == DONE);

endmodule

//--- src/token_engine.sv
`timescale 1ns/100ps

module token_engine import token_pkg::*; #(
    parameter int NUM_FIFO = 8,
    parameter int NUM_PE   = 8
) (
    input  logic                clk,
    input  logic                rst_i,

    input  logic                pass_start_i,
    input  pass_cfg_t           cfg_i,

    input  logic [DATA_W-1:0]   glb_read_data_i,
    input  logic [DATA_W-1:0]   opsum_fifo_pop_data_matrix_i [NUM_FIFO-1:0],
    input  logic [NUM_FIFO-1:0] ifmap_fifo_full_matrix_i,
    input  logic [NUM_FIFO-1:0] opsum_fifo_empty_matrix_i,

    output logic [ADDR_W-1:0]   glb_addr_o,
    output logic [3:0]          glb_web_o,
    output logic [DATA_W-1:0]   glb_write_data_o,

    output logic [WEIGHT_W-1:0] weight_in_o,
    output logic [NUM_PE-1:0]   weight_load_en_o,

    output logic                ifmap_fifo_reset_o,
    output logic                opsum_fifo_reset_o,
    output logic [NUM_FIFO-1:0] ifmap_fifo_push_matrix_o,
    output logic [DATA_W-1:0]   ifmap_fifo_push_data_o,
    output logic [NUM_FIFO-1:0] opsum_fifo_pop_matrix_o,

    output logic                pass_done_o
);

    phase_e            phase;
    glb_req_t          req;
    logic              fill_done;
    logic              drain_done;
    logic              weight_done;
    logic              weight_word_valid;
    logic [DATA_W-1:0] weight_word;

    pass_sequencer u_pass_sequencer (
        .clk                (clk),
        .rst_i              (rst_i),
        .pass_start_i       (pass_start_i),
        .weight_done_i      (weight_done),
        .fill_done_i        (fill_done),
        .drain_done_i       (drain_done),
        .phase_o            (phase),
        .ifmap_fifo_reset_o (ifmap_fifo_reset_o),
        .opsum_fifo_reset_o (opsum_fifo_reset_o),
        .pass_done_o        (pass_done_o)
    );

    glb_req_gen #(
        .NUM_FIFO (NUM_FIFO),
        .NUM_PE   (NUM_PE)
    ) u_glb_req_gen (
        .clk                       (clk),
        .rst_i                     (rst_i),
        .phase_i                   (phase),
        .cfg_i                     (cfg_i),
        .ifmap_fifo_full_matrix_i  (ifmap_fifo_full_matrix_i),
        .opsum_fifo_empty_matrix_i (opsum_fifo_empty_matrix_i),
        .req_o                     (req),
        .opsum_fifo_pop_matrix_o   (opsum_fifo_pop_matrix_o),
        .fill_done_o               (fill_done),
        .drain_done_o              (drain_done)
    );

    glb_port #(
        .NUM_FIFO (NUM_FIFO)
    ) u_glb_port (
        .clk                          (clk),
        .rst_i                        (rst_i),
        .req_i                        (req),
        .glb_read_data_i              (glb_read_data_i),
        .opsum_fifo_pop_data_matrix_i (opsum_fifo_pop_data_matrix_i),
        .glb_addr_o                   (glb_addr_o),
        .glb_web_o                    (glb_web_o),
        .glb_write_data_o             (glb_write_data_o),
        .ifmap_fifo_push_matrix_o     (ifmap_fifo_push_matrix_o),
        .ifmap_fifo_push_data_o       (ifmap_fifo_push_data_o),
        .weight_word_valid_o          (weight_word_valid),
        .weight_word_o                (weight_word)
    );

    weight_unpacker #(
        .NUM_PE (NUM_PE)
    ) u_weight_unpacker (
        .clk                 (clk),
        .rst_i               (rst_i),
        .weight_word_valid_i (weight_word_valid),
        .weight_word_i       (weight_word),
        .weight_in_o         (weight_in_o),
        .weight_load_en_o    (weight_load_en_o),
        .weight_done_o       (weight_done)
    );

endmodule

//--- src/token_pkg.sv
package token_pkg;

    // GLB port widths
    parameter int ADDR_W         = 32;
    parameter int DATA_W         = 32;
    parameter int WEIGHT_W       = 8;
    parameter int BYTES_PER_WORD = DATA_W / WEIGHT_W;

    // one pass walks these in order
    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,
        FIFO_RESET,
        IFMAP_FILL,
        OPSUM_DRAIN,
        DONE
    } phase_e;

    // which phase a GLB access belongs to
    typedef enum logic [1:0] {
        WEIGHT,
        IFMAP,
        OPSUM
    } req_kind_e;

    // per-pass configuration, bases are word addresses
    typedef struct packed {
        logic [ADDR_W-1:0] weight_base;
        logic [ADDR_W-1:0] ifmap_base;
        logic [ADDR_W-1:0] opsum_base;
        logic [7:0]        in_c;   // words per ifmap FIFO
        logic [7:0]        out_c;  // words per opsum FIFO
    } pass_cfg_t;

    // one GLB access, address already in bytes
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        fifo_idx;
        req_kind_e         kind;
    } glb_req_t;

endpackage

//--- src/weight_unpacker.sv
`timescale 1ns/100ps

module weight_unpacker import token_pkg::*; #(
    parameter int NUM_PE = 8
) (
    input  logic                clk,
    input  logic                rst_i,

    input  logic                weight_word_valid_i,
    input  logic [DATA_W-1:0]   weight_word_i,

    output logic [WEIGHT_W-1:0] weight_in_o,
    output logic [NUM_PE-1:0]   weight_load_en_o,
    output logic                weight_done_o
);

    localparam int PE_W   = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;
    localparam int BYTE_W = $clog2(BYTES_PER_WORD);

    logic [DATA_W-1:0] shift_q;   // lsb byte goes out first
    logic              busy_q;
    logic [BYTE_W-1:0] byte_cnt_q;
    logic [PE_W-1:0]   pe_cnt_q;
    logic              last_pe;

    assign last_pe = (pe_cnt_q == PE_W'(NUM_PE - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            byte_cnt_q <= '0;
            pe_cnt_q   <= '0;
        end else begin
            if (busy_q) begin
                pe_cnt_q <= last_pe ? '0 : pe_cnt_q + 1'b1;
            end
            // a new word may land on the cycle of the previous word's last byte
            if (weight_word_valid_i) begin
                busy_q     <= 1'b1;
                byte_cnt_q <= '0;
            end else if (busy_q) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
                if (byte_cnt_q == BYTE_W'(BYTES_PER_WORD - 1)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (weight_word_valid_i) begin
            shift_q <= weight_word_i;
        end else if (busy_q) begin
            shift_q <= shift_q >> WEIGHT_W;
        end
    end

    assign weight_in_o      = shift_q[WEIGHT_W-1:0];
    assign weight_load_en_o = busy_q ? (NUM_PE'(1) << pe_cnt_q) : '0;
    assign weight_done_o    = busy_q && last_pe;  // with the last byte

endmodule

//--- tests/tb_cases.svh
// one row per pass, applied in order
// columns: row, weight_base, ifmap_base, opsum_base, in_c, out_c, stall, pushes, writes

localparam int NUM_CASES = 5;

pass_cfg_t case_cfg    [NUM_CASES];
logic      case_stall  [NUM_CASES];
int        case_pushes [NUM_CASES];   // expected ifmap pushes for 8 FIFOs
int        case_writes [NUM_CASES];   // expected opsum writes for 8 FIFOs

task automatic set_case(
    input int                n,
    input logic [ADDR_W-1:0] weight_base,
    input logic [ADDR_W-1:0] ifmap_base,
    input logic [ADDR_W-1:0] opsum_base,
    input logic [7:0]        in_c,
    input logic [7:0]        out_c,
    input logic              stall,
    input int                pushes,
    input int                writes
);
    case_cfg[n].weight_base = weight_base;
    case_cfg[n].ifmap_base  = ifmap_base;
    case_cfg[n].opsum_base  = opsum_base;
    case_cfg[n].in_c        = in_c;
    case_cfg[n].out_c       = out_c;
    case_stall[n]           = stall;
    case_pushes[n]          = pushes;
    case_writes[n]          = writes;
endtask

task automatic load_cases();
    set_case(0, 32'h0000_0010, 32'h0000_1000, 32'h0000_8000, 8'd3,   8'd2, 1'b0, 24,   16);
    set_case(1, 32'h0000_0020, 32'h0000_2000, 32'h0000_9000, 8'd5,   8'd4, 1'b1, 40,   32);
    set_case(2, 32'h0000_3ffe, 32'h0000_4000, 32'h0000_a000, 8'd1,   8'd1, 1'b1, 8,    8);
    set_case(3, 32'h0000_0044, 32'h0000_0abc, 32'h0000_0123, 8'd16,  8'd7, 1'b1, 128,  56);
    set_case(4, 32'h0000_0100, 32'h0001_0000, 32'h0002_0000, 8'd255, 8'd1, 1'b0, 2040, 8);
endtask

//--- tests/tb_token_engine.sv
`timescale 1ns/100ps

module tb_token_engine import token_pkg::*; ();

    localparam int          NUM_FIFO = 8;
    localparam int          NUM_PE   = 8;
    localparam logic [31:0] MEM_KEY  = 32'h5a5a0000;   // glb word a holds a ^ key

    `include "tb_cases.svh"

    logic                clk = 1'b0;
    logic                rst_i;
    logic                pass_start_i;
    pass_cfg_t           cfg_i;
    logic [DATA_W-1:0]   glb_read_data_i;
    logic [DATA_W-1:0]   pop_data [NUM_FIFO-1:0];
    logic [NUM_FIFO-1:0] full_mask;
    logic [NUM_FIFO-1:0] empty_mask;

    logic [ADDR_W-1:0]   glb_addr_o;
    logic [3:0]          glb_web_o;
    logic [DATA_W-1:0]   glb_write_data_o;
    logic [WEIGHT_W-1:0] weight_in_o;
    logic [NUM_PE-1:0]   weight_load_en_o;
    logic                ifmap_fifo_reset_o;
    logic                opsum_fifo_reset_o;
    logic [NUM_FIFO-1:0] ifmap_fifo_push_matrix_o;
    logic [DATA_W-1:0]   ifmap_fifo_push_data_o;
    logic [NUM_FIFO-1:0] opsum_fifo_pop_matrix_o;
    logic                pass_done_o;

    integer              seed        = 32'h716cdacd;
    logic                stall_en    = 1'b0;
    logic                idle_check  = 1'b0;
    int                  cycle_cnt   = 0;
    int                  cycle_limit = 0;
    int                  err_cnt     = 0;
    int                  pass_cnt    = 0;
    int                  fail_cnt    = 0;
    int                  pop_cnt [NUM_FIFO];

    // scoreboard state of the running pass
    pass_cfg_t           cur_cfg;
    int                  pe_seen      = 0;
    int                  reset_cycles = 0;
    int                  done_seen    = 0;
    int                  push_seen    = 0;
    int                  push_idx     = 0;
    int                  push_word    = 0;
    int                  write_seen   = 0;
    int                  wr_fifo      = 0;
    int                  wr_word      = 0;
    logic [NUM_FIFO-1:0] full_d1      = '0;
    logic [NUM_FIFO-1:0] full_d2      = '0;
    logic [ADDR_W-1:0]   addr_d1      = '0;
    logic [3:0]          web_d1       = '0;

    token_engine #(
        .NUM_FIFO (NUM_FIFO),
        .NUM_PE   (NUM_PE)
    ) dut0 (
        .clk                          (clk),
        .rst_i                        (rst_i),
        .pass_start_i                 (pass_start_i),
        .cfg_i                        (cfg_i),
        .glb_read_data_i              (glb_read_data_i),
        .opsum_fifo_pop_data_matrix_i (pop_data),
        .ifmap_fifo_full_matrix_i     (full_mask),
        .opsum_fifo_empty_matrix_i    (empty_mask),
        .glb_addr_o                   (glb_addr_o),
        .glb_web_o                    (glb_web_o),
        .glb_write_data_o             (glb_write_data_o),
        .weight_in_o                  (weight_in_o),
        .weight_load_en_o             (weight_load_en_o),
        .ifmap_fifo_reset_o           (ifmap_fifo_reset_o),
        .opsum_fifo_reset_o           (opsum_fifo_reset_o),
        .ifmap_fifo_push_matrix_o     (ifmap_fifo_push_matrix_o),
        .ifmap_fifo_push_data_o       (ifmap_fifo_push_data_o),
        .opsum_fifo_pop_matrix_o      (opsum_fifo_pop_matrix_o),
        .pass_done_o                  (pass_done_o)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // glb read model, opsum FIFO model and random stalls
    always @(posedge clk) begin
        glb_read_data_i <= (glb_addr_o >> 2) ^ MEM_KEY;
        for (int i = 0; i < NUM_FIFO; i++) begin
            if (opsum_fifo_reset_o) begin
                pop_cnt[i] <= 0;
            end else if (opsum_fifo_pop_matrix_o[i]) begin
                pop_data[i] <= (i << 16) | pop_cnt[i];
                pop_cnt[i]  <= pop_cnt[i] + 1;
            end
        end
        if (stall_en) begin
            full_mask  <= $random(seed) & $random(seed);   // about one bit in four
            empty_mask <= $random(seed) & $random(seed);
        end else begin
            full_mask  <= '0;
            empty_mask <= '0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        err_cnt++;
    endtask

    task automatic violation(input string msg);
        $display("at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic quiet_outputs();
        if (ifmap_fifo_push_matrix_o !== '0)
            mismatch("ifmap_fifo_push_matrix_o", 0, ifmap_fifo_push_matrix_o);
        if (opsum_fifo_pop_matrix_o !== '0)
            mismatch("opsum_fifo_pop_matrix_o", 0, opsum_fifo_pop_matrix_o);
        if (ifmap_fifo_reset_o !== 1'b0)
            mismatch("ifmap_fifo_reset_o", 0, ifmap_fifo_reset_o);
        if (opsum_fifo_reset_o !== 1'b0)
            mismatch("opsum_fifo_reset_o", 0, opsum_fifo_reset_o);
        if (glb_web_o !== 4'b0000)
            mismatch("glb_web_o", 0, glb_web_o);
        if (pass_done_o !== 1'b0)
            mismatch("pass_done_o", 0, pass_done_o);
        if (weight_load_en_o !== '0)
            mismatch("weight_load_en_o", 0, weight_load_en_o);
    endtask

    task automatic weight_scoreboard();
        logic [NUM_PE-1:0] exp_hot;
        logic [31:0]       exp_word;
        logic [7:0]        exp_byte;
        if (weight_load_en_o !== '0) begin
            if (pe_seen >= NUM_PE) begin
                violation("weight byte after every PE was loaded");
            end else begin
                exp_hot           = '0;
                exp_hot[pe_seen]  = 1'b1;
                exp_word          = (cur_cfg.weight_base + pe_seen / 4) ^ MEM_KEY;
                exp_byte          = exp_word >> (8 * (pe_seen % 4));   // lsb first
                if (weight_load_en_o !== exp_hot)
                    mismatch("weight_load_en_o", exp_hot, weight_load_en_o);
                if (weight_in_o !== exp_byte)
                    mismatch("weight_in_o", exp_byte, weight_in_o);
            end
            pe_seen++;
        end
    endtask

    task automatic reset_pulse_check();
        if (ifmap_fifo_reset_o || opsum_fifo_reset_o) begin
            if (ifmap_fifo_reset_o !== opsum_fifo_reset_o)
                violation("ifmap and opsum FIFO resets did not pulse together");
            if (pe_seen != NUM_PE)
                violation("FIFO reset came before the last weight byte");
            if (push_seen != 0)
                violation("FIFO reset came after an ifmap push");
            reset_cycles++;
        end
    endtask

    task automatic push_scoreboard();
        logic [NUM_FIFO-1:0] exp_hot;
        logic [ADDR_W-1:0]   exp_addr;
        if (ifmap_fifo_push_matrix_o !== '0) begin
            if (reset_cycles == 0)
                violation("ifmap push before the FIFO reset");
            if (push_idx >= NUM_FIFO) begin
                violation("ifmap push after every FIFO was filled");
            end else begin
                exp_hot           = '0;
                exp_hot[push_idx] = 1'b1;
                exp_addr          = cur_cfg.ifmap_base + push_idx * cur_cfg.in_c + push_word;
                if (ifmap_fifo_push_matrix_o !== exp_hot)
                    mismatch("ifmap_fifo_push_matrix_o", exp_hot, ifmap_fifo_push_matrix_o);
                if (ifmap_fifo_push_data_o !== (exp_addr ^ MEM_KEY))
                    mismatch("ifmap_fifo_push_data_o", exp_addr ^ MEM_KEY,
                             ifmap_fifo_push_data_o);
                if (addr_d1 !== (exp_addr << 2))
                    mismatch("glb_addr_o", exp_addr << 2, addr_d1);
                if (web_d1 !== 4'b0000)
                    mismatch("glb_web_o", 4'b0000, web_d1);
                if (full_d2[push_idx])
                    violation($sformatf("push to ifmap FIFO %0d requested while full", push_idx));
                push_word++;
                if (push_word == cur_cfg.in_c) begin
                    push_word = 0;
                    push_idx++;
                end
            end
            push_seen++;
        end
    endtask

    task automatic write_scoreboard();
        logic [ADDR_W-1:0] exp_addr;
        logic [DATA_W-1:0] exp_data;
        if (glb_web_o !== 4'b0000) begin
            if (glb_web_o !== 4'b1111)
                mismatch("glb_web_o", 4'b1111, glb_web_o);
            if (wr_fifo >= NUM_FIFO) begin
                violation("opsum write after every FIFO was drained");
            end else begin
                exp_addr = (cur_cfg.opsum_base + wr_fifo * cur_cfg.out_c + wr_word) << 2;
                exp_data = (wr_fifo << 16) | wr_word;
                if (glb_addr_o !== exp_addr)
                    mismatch("glb_addr_o", exp_addr, glb_addr_o);
                if (glb_write_data_o !== exp_data)
                    mismatch("glb_write_data_o", exp_data, glb_write_data_o);
                wr_word++;
                if (wr_word == cur_cfg.out_c) begin
                    wr_word = 0;
                    wr_fifo++;
                end
            end
            write_seen++;
        end
    endtask

    task automatic pop_guard();
        logic [NUM_FIFO-1:0] pops;
        pops = opsum_fifo_pop_matrix_o;
        if ((pops & (pops - 1'b1)) != '0)
            violation("more than one opsum FIFO popped in one cycle");
        if ((pops & empty_mask) != '0)
            violation("pop from an empty opsum FIFO");
    endtask

    task automatic done_check();
        if (pass_done_o) begin
            if (write_seen != NUM_FIFO * cur_cfg.out_c)
                violation("pass_done_o came before the last opsum write");
            done_seen++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_i || idle_check) begin
            quiet_outputs();
        end else begin
            weight_scoreboard();
            reset_pulse_check();
            push_scoreboard();
            write_scoreboard();
            pop_guard();
            done_check();
        end
        // request-time history for the push checks
        full_d2 = full_d1;
        full_d1 = full_mask;
        addr_d1 = glb_addr_o;
        web_d1  = glb_web_o;
    end

    task automatic run_case(input int c);
        int errs_before;
        errs_before = err_cnt;
        @(posedge clk);
        cur_cfg      = case_cfg[c];
        pe_seen      = 0;
        reset_cycles = 0;
        done_seen    = 0;
        push_seen    = 0;
        push_idx     = 0;
        push_word    = 0;
        write_seen   = 0;
        wr_fifo      = 0;
        wr_word      = 0;
        cfg_i        <= case_cfg[c];
        stall_en     <= case_stall[c];
        pass_start_i <= 1'b1;
        @(posedge clk);
        pass_start_i <= 1'b0;
        while (done_seen == 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);   // anything after done is an error
        if (pe_seen != NUM_PE)
            violation($sformatf("%0d weight bytes instead of %0d", pe_seen, NUM_PE));
        if (reset_cycles != 1)
            violation($sformatf("FIFO reset high for %0d cycles", reset_cycles));
        if (push_seen != case_pushes[c])
            violation($sformatf("%0d ifmap pushes instead of %0d", push_seen, case_pushes[c]));
        if (write_seen != case_writes[c])
            violation($sformatf("%0d opsum writes instead of %0d", write_seen, case_writes[c]));
        if (done_seen != 1)
            violation($sformatf("pass_done_o pulsed %0d times", done_seen));
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("case %0d in_c=%0d out_c=%0d stall=%0b ok", c, cur_cfg.in_c,
                     cur_cfg.out_c, case_stall[c]);
        end else begin
            fail_cnt++;
            $display("case %0d in_c=%0d out_c=%0d stall=%0b failed with %0d errors", c,
                     cur_cfg.in_c, cur_cfg.out_c, case_stall[c], err_cnt - errs_before);
        end
    endtask

    initial begin
        load_cases();
        for (int c = 0; c < NUM_CASES; c++) begin
            cycle_limit += 4 * (NUM_PE / 4)
                           + 4 * NUM_FIFO * (int'(case_cfg[c].in_c) + int'(case_cfg[c].out_c))
                           + 50;
        end
        rst_i           = 1'b1;
        pass_start_i    = 1'b0;
        cfg_i           = '0;
        glb_read_data_i = '0;
        full_mask       = '0;
        empty_mask      = '0;
        for (int i = 0; i < NUM_FIFO; i++) begin
            pop_data[i] = '0;
            pop_cnt[i]  = 0;
        end
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        idle_check = 1'b1;           // no start yet so nothing may move
        repeat (6) @(posedge clk);
        idle_check = 1'b0;
        if (err_cnt == 0) begin
            pass_cnt++;
            $display("reset and idle ok");
        end else begin
            fail_cnt++;
            $display("reset and idle failed with %0d errors", err_cnt);
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", pass_cnt + fail_cnt,
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
